// File: Bender.yml
package:
  name: boot_loader

sources:
  # Package and channel interface first
  - src/boot_pkg.sv
  - src/word_hs_if.sv
  # Boot path RTL
  - src/flash_reader.sv
  - src/word_fifo.sv
  - src/sdram_writer.sv
  - src/boot_loader_top.sv
  # Testbench
  - target: test
    files:
      - tests/boot_loader_tb.sv

// File: src/boot_loader_top.sv
`timescale 1ns/1ps

module boot_loader_top
(
	input  logic                                i_Clk,
	input  logic                                Internal_Reset_n,

	// Parallel flash
	output logic [boot_pkg::FlashAddrWidth-1:0] o_FlAddr,
	input  logic [boot_pkg::FlashDataWidth-1:0] i_FlData,
	output logic                                o_FlChipEn_n,
	output logic                                o_FlOutputEn_n,

	// Main memory write port
	output logic                                o_MemReq,
	output logic [boot_pkg::MemAddrWidth-1:0]   o_MemAddr,
	output logic [boot_pkg::DataWidth-1:0]      o_MemData,
	input  logic                                i_MemAck,

	output logic                                o_Done	// Releases the processor
);

	// ==============================
	// Internal channels
	// ==============================
	word_hs_if ReaderHs ();	// Reader to buffer
	word_hs_if WriterHs ();	// Buffer to writer

	// Flash bytes into packed words
	flash_reader FLASH_READER
	(
		.i_Clk(i_Clk),
		.Internal_Reset_n(Internal_Reset_n),
		.o_FlAddr(o_FlAddr),
		.i_FlData(i_FlData),
		.o_FlChipEn_n(o_FlChipEn_n),
		.o_FlOutputEn_n(o_FlOutputEn_n),
		.o_Out(ReaderHs.Sender)
	);

	// Decouples flash rate from memory Ack delay
	word_fifo WORD_FIFO
	(
		.i_Clk(i_Clk),
		.Internal_Reset_n(Internal_Reset_n),
		.i_In(ReaderHs.Receiver),
		.o_Out(WriterHs.Sender)
	);

	sdram_writer SDRAM_WRITER
	(
		.i_Clk(i_Clk),
		.Internal_Reset_n(Internal_Reset_n),
		.i_In(WriterHs.Receiver),
		.o_MemReq(o_MemReq),
		.o_MemAddr(o_MemAddr),
		.o_MemData(o_MemData),
		.i_MemAck(i_MemAck),
		.o_Done(o_Done)
	);

endmodule

// File: src/boot_pkg.sv
package boot_pkg;

	// ==============================
	// Bus widths
	// ==============================
	localparam int DataWidth      = 32;	// Main memory word
	localparam int MemAddrWidth   = 22;	// Word address on memory port
	localparam int FlashAddrWidth = 22;	// Byte address on flash
	localparam int FlashDataWidth = 8;	// Flash data bus
	localparam int BytesPerWord   = 4;	// Flash bytes per memory word

	// ==============================
	// Boot load and flash timing
	// ==============================
	localparam int WordsToLoad         = 64;	// Short image for simulation
	localparam int FlashReadWaitCycles = 3;	// Address hold before sample

	// Word buffer between reader and writer
	localparam int FifoDepth = 8;

	// ==============================
	// Derived counter widths
	// ==============================
	localparam int WordCountWidth = $clog2(WordsToLoad);
	localparam int WaitCountWidth = $clog2(FlashReadWaitCycles + 1);
	localparam int ByteIdxWidth   = $clog2(BytesPerWord);
	localparam int FifoPtrWidth   = $clog2(FifoDepth);
	localparam int FifoCountWidth = $clog2(FifoDepth + 1);	// Must reach FifoDepth itself

	// Record passed between the boot units
	typedef struct packed
	{
		logic [MemAddrWidth-1:0] Addr;	// Word address in main memory
		logic [DataWidth-1:0]    Data;	// Packed little-endian word
	} memWord_t;

endpackage

// File: src/flash_reader.sv
`timescale 1ns/1ps

module flash_reader
(
	input  logic                                i_Clk,
	input  logic                                Internal_Reset_n,

	// Parallel flash, read only
	output logic [boot_pkg::FlashAddrWidth-1:0] o_FlAddr,
	input  logic [boot_pkg::FlashDataWidth-1:0] i_FlData,
	output logic                                o_FlChipEn_n,
	output logic                                o_FlOutputEn_n,

	// Packed words toward the buffer
	word_hs_if.Sender                           o_Out
);

	typedef enum logic [1:0]
	{
		ST_IDLE,	// First cycle out of reset
		ST_READ,	// Stepping through flash bytes
		ST_HOLD,	// Full word waiting for the offer slot
		ST_DONE	// Whole image read
	} readerState_t;

	readerState_t State;

	logic [boot_pkg::FlashAddrWidth-1:0] ByteAddr;
	logic [boot_pkg::WaitCountWidth-1:0] WaitCount;	// Cycles address has been held
	logic [boot_pkg::ByteIdxWidth-1:0]   ByteIdx;	// Byte slot within word
	logic [boot_pkg::WordCountWidth-1:0] WordCount;	// Words handed to the offer register
	logic                                FlashEn;
	logic [boot_pkg::DataWidth-1:0]      WordReg;	// Word under assembly
	logic [boot_pkg::DataWidth-1:0]      ShiftedWord;

	logic               OfferReq;
	boot_pkg::memWord_t OfferWord;

	logic ByteDone;
	logic WordDone;
	logic SlotFree;
	logic LoadOffer;
	logic LastWord;

	// ==============================
	// Byte and word strobes
	// ==============================
	assign ByteDone = (State == ST_READ) &&
		(WaitCount == (boot_pkg::WaitCountWidth)'(boot_pkg::FlashReadWaitCycles));
	assign WordDone = ByteDone && (ByteIdx == (boot_pkg::ByteIdxWidth)'(boot_pkg::BytesPerWord - 1));
	assign SlotFree = !OfferReq && !o_Out.Ack;	// Previous handshake fully closed
	assign LoadOffer = SlotFree && (WordDone || (State == ST_HOLD));
	assign LastWord = (WordCount == (boot_pkg::WordCountWidth)'(boot_pkg::WordsToLoad - 1));

	// New byte enters at the top, so byte 0 ends up in bits 7:0
	assign ShiftedWord = {i_FlData, WordReg[boot_pkg::DataWidth-1:boot_pkg::FlashDataWidth]};

	// ==============================
	// Flash address walker
	// ==============================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			State     <= ST_IDLE;
			ByteAddr  <= '0;
			WaitCount <= '0;
			ByteIdx   <= '0;
			FlashEn   <= 1'b0;
		end
		else
		begin
			case (State)
				ST_IDLE:
				begin
					State   <= ST_READ;
					FlashEn <= 1'b1;	// Enables go low from here
				end
				ST_READ:
				begin
					if (ByteDone)
					begin
						WaitCount <= '0;
						ByteAddr  <= ByteAddr + 1'b1;
						ByteIdx   <= ByteIdx + 1'b1;	// Wraps after last byte of word
						if (WordDone)
						begin
							if (LastWord)
								FlashEn <= 1'b0;	// Final byte sampled
							if (!SlotFree)
								State <= ST_HOLD;	// Stop fetching until the slot frees
							else if (LastWord)
								State <= ST_DONE;
						end
					end
					else
						WaitCount <= WaitCount + 1'b1;
				end
				ST_HOLD:
				begin
					if (SlotFree)
						State <= LastWord ? ST_DONE : ST_READ;
				end
				default: ;	// ST_DONE is terminal
			endcase
		end
	end

	// Sampled bytes shift in here
	always_ff @(posedge i_Clk)
	begin
		if (ByteDone)
			WordReg <= ShiftedWord;
	end

	// ==============================
	// Offer register, sender side
	// ==============================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			OfferReq  <= 1'b0;
			WordCount <= '0;
		end
		else if (LoadOffer)
		begin
			OfferReq  <= 1'b1;
			WordCount <= WordCount + 1'b1;
		end
		else if (OfferReq && o_Out.Ack)
			OfferReq <= 1'b0;	// Receiver took it
	end

	always_ff @(posedge i_Clk)
	begin
		if (LoadOffer)
		begin
			OfferWord.Addr <= (boot_pkg::MemAddrWidth)'(WordCount);
			OfferWord.Data <= (State == ST_HOLD) ? WordReg : ShiftedWord;
		end
	end

	assign o_Out.Req  = OfferReq;
	assign o_Out.Word = OfferWord;

	assign o_FlAddr       = ByteAddr;
	assign o_FlChipEn_n   = !FlashEn;
	assign o_FlOutputEn_n = !FlashEn;

	// Flash needs a steady address for the whole read wait
	AddrHeldDuringWait: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		(State == ST_READ && WaitCount != '0) |-> $stable(o_FlAddr))
		else $error("Flash address moved during read wait");

endmodule

// File: src/sdram_writer.sv
`timescale 1ns/1ps

module sdram_writer
(
	input  logic                              i_Clk,
	input  logic                              Internal_Reset_n,
	word_hs_if.Receiver                       i_In,	// Words from the buffer

	// Main memory write port, four-phase
	output logic                              o_MemReq,
	output logic [boot_pkg::MemAddrWidth-1:0] o_MemAddr,
	output logic [boot_pkg::DataWidth-1:0]    o_MemData,
	input  logic                              i_MemAck,

	output logic                              o_Done	// Boot image fully written
);

	typedef enum logic [1:0]
	{
		ST_IDLE,	// Ready for next word
		ST_WRITE,	// Req high, waiting for memory Ack
		ST_RELEASE,	// Req dropped, waiting for Ack low
		ST_DONE
	} writerState_t;

	writerState_t State;

	logic                                InAck;
	logic                                MemReq;
	logic [boot_pkg::WordCountWidth-1:0] WriteCount;	// Completed memory writes
	logic                                TakeWord;

	assign TakeWord = (State == ST_IDLE) && i_In.Req && !InAck;

	// ==============================
	// Write sequencer
	// ==============================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			State      <= ST_IDLE;
			InAck      <= 1'b0;
			MemReq     <= 1'b0;
			WriteCount <= '0;
		end
		else
		begin
			// Buffer side Ack follows Req down one cycle later
			if (TakeWord)
				InAck <= 1'b1;
			else if (InAck && !i_In.Req)
				InAck <= 1'b0;

			case (State)
				ST_IDLE:
				begin
					if (TakeWord)
					begin
						MemReq <= 1'b1;	// Same cycle as the buffer Ack
						State  <= ST_WRITE;
					end
				end
				ST_WRITE:
				begin
					if (i_MemAck)
					begin
						MemReq <= 1'b0;
						State  <= ST_RELEASE;
					end
				end
				ST_RELEASE:
				begin
					if (!i_MemAck)	// Handshake closed
					begin
						WriteCount <= WriteCount + 1'b1;
						if (WriteCount == (boot_pkg::WordCountWidth)'(boot_pkg::WordsToLoad - 1))
							State <= ST_DONE;
						else
							State <= ST_IDLE;
					end
				end
				default: ;	// Stays done until reset
			endcase
		end
	end

	// Latched write payload
	always_ff @(posedge i_Clk)
	begin
		if (TakeWord)
		begin
			o_MemAddr <= i_In.Word.Addr;
			o_MemData <= i_In.Word.Data;
		end
	end

	assign i_In.Ack = InAck;
	assign o_MemReq = MemReq;
	assign o_Done   = (State == ST_DONE);

	// Req may only drop after memory answered
	ReqHeldForAck: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		$fell(o_MemReq) |-> $past(i_MemAck))
		else $error("o_MemReq dropped before i_MemAck");

endmodule

// File: src/word_fifo.sv
`timescale 1ns/1ps

module word_fifo
(
	input  logic        i_Clk,
	input  logic        Internal_Reset_n,
	word_hs_if.Receiver i_In,	// From flash reader
	word_hs_if.Sender   o_Out	// Toward memory writer
);

	boot_pkg::memWord_t Mem [boot_pkg::FifoDepth];	// Circular storage

	logic [boot_pkg::FifoPtrWidth-1:0]   WrPtr;
	logic [boot_pkg::FifoPtrWidth-1:0]   RdPtr;
	logic [boot_pkg::FifoCountWidth-1:0] Count;	// Stored, not yet offered

	logic               InAck;
	logic               OutReq;
	boot_pkg::memWord_t OutWord;

	logic Full;
	logic WrEn;
	logic RdEn;

	assign Full = (Count == (boot_pkg::FifoCountWidth)'(boot_pkg::FifoDepth));
	assign WrEn = i_In.Req && !InAck && !Full;	// Holding Ack back is the back-pressure
	assign RdEn = !OutReq && !o_Out.Ack && (Count != '0);

	// ==============================
	// Pointers and handshakes
	// ==============================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			WrPtr  <= '0;
			RdPtr  <= '0;
			Count  <= '0;
			InAck  <= 1'b0;
			OutReq <= 1'b0;
		end
		else
		begin
			// Input side
			if (WrEn)
			begin
				InAck <= 1'b1;
				WrPtr <= WrPtr + 1'b1;	// Depth is a power of two
			end
			else if (InAck && !i_In.Req)
				InAck <= 1'b0;

			// Output side
			if (RdEn)
			begin
				OutReq <= 1'b1;
				RdPtr  <= RdPtr + 1'b1;
			end
			else if (OutReq && o_Out.Ack)
				OutReq <= 1'b0;

			case ({WrEn, RdEn})
				2'b10:   Count <= Count + 1'b1;
				2'b01:   Count <= Count - 1'b1;
				default: ;	// Level unchanged on both or neither
			endcase
		end
	end

	// Storage and output word
	always_ff @(posedge i_Clk)
	begin
		if (WrEn)
			Mem[WrPtr] <= i_In.Word;
		if (RdEn)
			OutWord <= Mem[RdPtr];
	end

	assign i_In.Ack   = InAck;
	assign o_Out.Req  = OutReq;
	assign o_Out.Word = OutWord;

	// Pointers alone must show a free slot on every write
	NoWriteWhenFull: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		WrEn |-> ((WrPtr != RdPtr) || (Count == '0)))
		else $error("Word accepted while buffer full");

	OutWordStable: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		($past(o_Out.Req) && o_Out.Req) |-> $stable(o_Out.Word))
		else $error("Output word changed while Req high");

endmodule

// File: src/word_hs_if.sv
`timescale 1ns/1ps

// Four-phase req/ack channel carrying one memory word record
interface word_hs_if;

	logic              Req;	// Word valid, held until Ack seen
	logic              Ack;	// Receiver has taken Word
	boot_pkg::memWord_t Word;	// Stable while Req high

	// Producer side
	modport Sender
	(
		output Req,
		output Word,
		input  Ack
	);

	// Consumer side
	modport Receiver
	(
		input  Req,
		input  Word,
		output Ack
	);

endinterface

// File: tests/boot_loader_tb.sv
`timescale 1ns/1ps

module boot_loader_tb;

	// ==============================
	// Bench constants
	// ==============================
	localparam int          ClkPeriod    = 8;	// ns
	localparam int          ResetCycles  = 16;
	localparam logic [31:0] LfsrSeed     = 32'h73a09246;
	localparam int          MaxAckDelay  = 15;	// Fits four LFSR bits
	localparam logic [7:0]  FlashPattern = 8'hA5;	// Flash byte = low address bits ^ pattern
	localparam int          SlowWords    = 32;	// Long acks early so the buffer fills
	localparam int          NumTests     = 5;
	localparam int          WatchdogCycles = 2 * boot_pkg::WordsToLoad *
		(boot_pkg::BytesPerWord * (boot_pkg::FlashReadWaitCycles + 1) + 20);

	logic                                Clk;
	logic                                Internal_Reset_n;
	logic [boot_pkg::FlashAddrWidth-1:0] FlAddr;
	logic [boot_pkg::FlashDataWidth-1:0] FlData;
	logic                                FlChipEn_n;
	logic                                FlOutputEn_n;
	logic                                MemReq;
	logic [boot_pkg::MemAddrWidth-1:0]   MemAddr;
	logic [boot_pkg::DataWidth-1:0]      MemData;
	logic                                MemAck;
	logic                                Done;

	logic [31:0]                         LfsrState;
	int                                  WritesSeen;	// Completed memory handshakes
	int                                  HeldCycles;	// Negedges on the same flash address
	logic [boot_pkg::FlashAddrWidth-1:0] LastFlAddr;
	logic                                StallSeen;	// Reader held back by a full buffer
	int                                  ErrCount [NumTests];

	boot_loader_top UUT
	(
		.i_Clk(Clk),
		.Internal_Reset_n(Internal_Reset_n),
		.o_FlAddr(FlAddr),
		.i_FlData(FlData),
		.o_FlChipEn_n(FlChipEn_n),
		.o_FlOutputEn_n(FlOutputEn_n),
		.o_MemReq(MemReq),
		.o_MemAddr(MemAddr),
		.o_MemData(MemData),
		.i_MemAck(MemAck),
		.o_Done(Done)
	);

	// ==============================
	// Helpers
	// ==============================
	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] State);
		return {State[30:0], State[31] ^ State[21] ^ State[1] ^ State[0]};
	endfunction

	task automatic drawAckDelay(output int Delay);
		Delay = 0;
		for (int i = 0; i < $clog2(MaxAckDelay + 1); i++)
		begin
			LfsrState = lfsrNext(LfsrState);	// One step per bit taken
			Delay = (Delay << 1) | LfsrState[0];
		end
		if (WritesSeen < SlowWords)
			Delay = Delay | 12;	// 12 to 15 in the slow stretch
	endtask

	function automatic logic [7:0] flashByte(input logic [boot_pkg::FlashAddrWidth-1:0] Addr);
		return Addr[7:0] ^ FlashPattern;
	endfunction

	// Word k packs bytes 4k to 4k+3 little-endian
	function automatic logic [boot_pkg::DataWidth-1:0] packedWord(input int Index);
		logic [boot_pkg::DataWidth-1:0] Word;
		Word = '0;
		for (int j = 0; j < boot_pkg::BytesPerWord; j++)
			Word[boot_pkg::FlashDataWidth*j +: boot_pkg::FlashDataWidth] =
				flashByte((boot_pkg::FlashAddrWidth)'(Index * boot_pkg::BytesPerWord + j));
		return Word;
	endfunction

	task automatic valueError(input int Test, input string Name,
		input logic [31:0] Expected, input logic [31:0] Actual);
		$display("[ERROR] %0t ns %s expected %h got %h", $time, Name, Expected, Actual);
		ErrCount[Test]++;
	endtask

	task automatic plainError(input int Test, input string What);
		$display("Problem at %0t ns: %s", $time, What);
		ErrCount[Test]++;
	endtask

	task automatic reportTest(input int Test, input string Name);
		if (ErrCount[Test] == 0)
			$display("%s ... ok", Name);
		else
			$display("%s ... FAILED with %0d errors", Name, ErrCount[Test]);
	endtask

	// ==============================
	// Clock, flash and memory models
	// ==============================
	initial
	begin
		Clk = 1'b0;
		forever
			#(ClkPeriod / 2) Clk = ~Clk;
	end

	// Any address readable, bus pulled high while the flash is not enabled
	always @(negedge Clk)
		FlData = (!FlChipEn_n && !FlOutputEn_n) ? flashByte(FlAddr) : 8'hFF;

	initial
	begin : MemoryModel
		int Delay;
		MemAck = 1'b0;
		WritesSeen = 0;
		LfsrState = LfsrSeed;
		forever
		begin
			@(negedge Clk);
			if (MemReq)
			begin
				drawAckDelay(Delay);
				repeat (Delay) @(negedge Clk);
				MemAck = 1'b1;
				while (MemReq)
					@(negedge Clk);
				repeat (Delay) @(negedge Clk);	// Same delay before releasing Ack
				MemAck = 1'b0;
				WritesSeen++;	// Handshake closed
			end
		end
	end

	// Reader stall shows up as a flash address held past one byte time
	always @(negedge Clk)
	begin
		if (!FlChipEn_n && FlAddr == LastFlAddr)
			HeldCycles++;
		else
			HeldCycles = 0;
		LastFlAddr = FlAddr;
		if (HeldCycles > boot_pkg::FlashReadWaitCycles + 1)
			StallSeen = 1'b1;
	end

	// ==============================
	// Checks
	// ==============================
	ResetQuiet: assert property (@(posedge Clk) !Internal_Reset_n |->
		({MemReq, Done, FlChipEn_n, FlOutputEn_n} == 4'b0011))
		else valueError(0, "{o_MemReq,o_Done,o_FlChipEn_n,o_FlOutputEn_n}", 4'b0011,
			{MemReq, Done, FlChipEn_n, FlOutputEn_n});

	AddrInOrder: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		$rose(MemAck) |-> (MemAddr == (boot_pkg::MemAddrWidth)'(WritesSeen)))
		else valueError(1, "o_MemAddr", WritesSeen, MemAddr);
	DataPacked: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		$rose(MemAck) |-> (MemData == packedWord(WritesSeen)))
		else valueError(1, "o_MemData", packedWord(WritesSeen), MemData);

	PayloadStable: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		(MemReq && $past(MemReq)) |-> ($stable(MemAddr) && $stable(MemData)))
		else plainError(2, "o_MemAddr or o_MemData changed while o_MemReq was high");
	ReqRiseAckLow: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		$rose(MemReq) |-> !$past(MemAck))
		else plainError(2, "o_MemReq rose while i_MemAck was still high");
	ReqFallAfterAck: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		$fell(MemReq) |-> $past(MemAck))
		else plainError(2, "o_MemReq fell before i_MemAck rose");

	WithinImage: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		$rose(MemAck) |-> (WritesSeen < boot_pkg::WordsToLoad))
		else plainError(3, "memory write past the end of the boot image");

	DoneAfterLast: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		$rose(Done) |-> (WritesSeen == boot_pkg::WordsToLoad))
		else valueError(4, "writes before o_Done", boot_pkg::WordsToLoad, WritesSeen);
	QuietAfterDone: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		Done |-> (!MemReq && FlChipEn_n && FlOutputEn_n))
		else plainError(4, "o_MemReq or a flash enable active after o_Done");
	DoneHeld: assert property (@(posedge Clk) disable iff (!Internal_Reset_n)
		Done |=> Done)
		else plainError(4, "o_Done dropped before reset");

	// ==============================
	// Sequence and watchdog
	// ==============================
	initial
	begin : MainSequence
		int Failed;
		Internal_Reset_n = 1'b0;
		FlData = '0;
		StallSeen = 1'b0;
		HeldCycles = 0;
		LastFlAddr = '0;
		Failed = 0;
		foreach (ErrCount[i])
			ErrCount[i] = 0;
		repeat (ResetCycles) @(negedge Clk);
		Internal_Reset_n = 1'b1;
		reportTest(0, "Reset state");

		while (!Done)
			@(negedge Clk);
		repeat (20) @(negedge Clk);	// Watch for stray requests after done

		if (WritesSeen != boot_pkg::WordsToLoad)
			valueError(3, "completed writes", boot_pkg::WordsToLoad, WritesSeen);
		if (!StallSeen)
			plainError(3, "flash reader never stalled, buffer never filled");
		reportTest(1, "Word content and order");
		reportTest(2, "Handshake rule");
		reportTest(3, "Back-pressure");
		reportTest(4, "Completion");

		foreach (ErrCount[i])
			if (ErrCount[i] != 0)
				Failed++;
		$display("Summary: %0d tests ok, %0d failing", NumTests - Failed, Failed);
		if (Failed == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * ClkPeriod);
		$display("Timeout: o_Done not seen within %0d cycles", WatchdogCycles);
		$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
src/boot_pkg.sv
src/word_hs_if.sv
src/flash_reader.sv
src/word_fifo.sv
src/sdram_writer.sv
src/boot_loader_top.sv
tests/boot_loader_tb.sv
